/* pixelPkg.sv */
// Fragment pipeline definitions
`default_nettype none

package pixelPkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////
    localparam int SUB_PIXEL_WIDTH    = 8;
    localparam int PIXEL_WIDTH        = 4 * SUB_PIXEL_WIDTH;
    localparam int INDEX_WIDTH        = 14;
    localparam int SCREEN_POS_WIDTH   = 11;
    localparam int FLOAT_WIDTH        = 32;
    localparam int TEX_ADDR_WIDTH     = 16;

    // IEEE-754 single precision fields
    localparam int FLOAT_EXP_WIDTH    = 8;
    localparam int FLOAT_MANT_WIDTH   = 23;
    localparam int FLOAT_EXP_BIAS     = 127;

    // Fog table and its load stream
    localparam int FOG_LUT_DEPTH      = 64;
    localparam int FOG_INDEX_WIDTH    = $clog2(FOG_LUT_DEPTH);
    localparam int LUT_STREAM_WIDTH   = 64;
    localparam int LUT_BYTES_PER_BEAT = LUT_STREAM_WIDTH / SUB_PIXEL_WIDTH;
    localparam int LUT_BEATS          = FOG_LUT_DEPTH / LUT_BYTES_PER_BEAT;

    ////////////////////////////////////////////////////////////
    // Stage latencies in clock cycles
    ////////////////////////////////////////////////////////////
    localparam int CONVERT_LATENCY    = 4;
    localparam int TEX_LATENCY        = 3;
    localparam int FOG_LATENCY        = 2;
    localparam int PIPE_LATENCY       = CONVERT_LATENCY + TEX_LATENCY + FOG_LATENCY;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [SUB_PIXEL_WIDTH-1:0] r;
        logic [SUB_PIXEL_WIDTH-1:0] g;
        logic [SUB_PIXEL_WIDTH-1:0] b;
        logic [SUB_PIXEL_WIDTH-1:0] a;
    } rgbaT;

    // Fragment as delivered by the interpolator, attributes in float
    typedef struct packed {
        logic [INDEX_WIDTH-1:0]      index;
        logic [SCREEN_POS_WIDTH-1:0] screenX;
        logic [SCREEN_POS_WIDTH-1:0] screenY;
        logic [FLOAT_WIDTH-1:0]      depthZ;
        logic [FLOAT_WIDTH-1:0]      depthW;
        logic [FLOAT_WIDTH-1:0]      texS;
        logic [FLOAT_WIDTH-1:0]      texT;
        logic [FLOAT_WIDTH-1:0]      colorR;
        logic [FLOAT_WIDTH-1:0]      colorG;
        logic [FLOAT_WIDTH-1:0]      colorB;
        logic [FLOAT_WIDTH-1:0]      colorA;
    } fragmentInT;

    // Travels beside the colour, depth already in fixed point
    typedef struct packed {
        logic [INDEX_WIDTH-1:0]      index;
        logic [SCREEN_POS_WIDTH-1:0] screenX;
        logic [SCREEN_POS_WIDTH-1:0] screenY;
        logic [31:0]                 depth;
    } fragMetaT;

    typedef enum logic [1:0] {
        REPLACE  = 2'd0,
        MODULATE = 2'd1,
        ADD      = 2'd2
    } texModeT;

    typedef struct packed {
        logic    texEnable;
        texModeT texMode;
        logic    fogEnable;
        rgbaT    fogColor;
    } pipeConfT;

endpackage

`default_nettype wire

/* floatToFixed.sv */
// Float to fixed point converter
`timescale 1ns/10ps
`default_nettype none

module floatToFixed
    import pixelPkg::*;
#(
    parameter int EXP_BIAS_OFFSET = 0
)
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire  [FLOAT_WIDTH-1:0] in,
    output logic [FLOAT_WIDTH-1:0] out
);

    logic                        drop1;
    logic [FLOAT_EXP_WIDTH-1:0]  exp1;
    logic [FLOAT_MANT_WIDTH:0]   mant1;
    logic                        drop2;
    logic signed [10:0]          shift2;
    logic [FLOAT_MANT_WIDTH:0]   mant2;
    logic                        drop3;
    logic                        sat3;
    logic [FLOAT_WIDTH-1:0]      shifted3;
    logic [FLOAT_WIDTH-1:0]      mantWide;
    logic [10:0]                 rightAmount;

    assign mantWide    = FLOAT_WIDTH'(mant2);
    assign rightAmount = -shift2;

    always_ff @(posedge clk)
    begin
        // Step 1: split fields, negatives and zero/denormals give 0
        drop1 <= in[FLOAT_WIDTH-1] | (in[FLOAT_WIDTH-2 -: FLOAT_EXP_WIDTH] == '0);
        exp1  <= in[FLOAT_WIDTH-2 -: FLOAT_EXP_WIDTH];
        mant1 <= {1'b1, in[FLOAT_MANT_WIDTH-1:0]};

        // Step 2: net shift of the 24-bit mantissa
        drop2  <= drop1;
        mant2  <= mant1;
        shift2 <= 11'({3'b000, exp1})
            - 11'(FLOAT_EXP_BIAS + FLOAT_MANT_WIDTH + EXP_BIAS_OFFSET);

        // Step 3: a 24-bit mantissa fits up to a left shift of 8
        drop3    <= drop2;
        sat3     <= (shift2 > 11'sd8);
        shifted3 <= shift2[10] ? (mantWide >> rightAmount) : (mantWide << shift2[3:0]);
    end

    // Step 4
    always_ff @(posedge clk)
    begin
        if (rst)
            out <= '0;
        else if (drop3)
            out <= '0;
        else if (sat3)
            out <= '1;
        else
            out <= shifted3;
    end

endmodule

`default_nettype wire

/* valueDelay.sv */
// Delay line for pipeline payloads
`timescale 1ns/10ps
`default_nettype none

module valueDelay
#(
    parameter type payloadT = logic,
    parameter int  DELAY    = 1
)
(
    input  wire     clk,
    input  wire     rst,
    input  wire     inValid,
    input  wire     payloadT in,
    output logic    outValid,
    output payloadT out
);

    payloadT          stages [DELAY];
    logic [DELAY-1:0] validPipe;

    always_ff @(posedge clk)
    begin
        stages[0] <= in;
        for (int i = 1; i < DELAY; i++)
        begin
            stages[i] <= stages[i-1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            validPipe <= '0;
        else
        begin
            validPipe[0] <= inValid;
            for (int i = 1; i < DELAY; i++)
            begin
                validPipe[i] <= validPipe[i-1];
            end
        end
    end

    assign outValid = validPipe[DELAY-1];
    assign out      = stages[DELAY-1];

endmodule

`default_nettype wire

/* attributeConvert.sv */
// Fragment attribute conversion
`timescale 1ns/10ps
`default_nettype none

module attributeConvert
    import pixelPkg::*;
(
    input  wire                        clk,
    input  wire                        rst,
    input  wire fragmentInT            fragIn,
    input  wire                        fragValid,
    output rgbaT                       color,
    output logic [31:0]                texS,
    output logic [31:0]                texT,
    output logic [31:0]                depthZ,
    output logic [FOG_INDEX_WIDTH-1:0] fogIndex,
    output fragMetaT                   meta,
    output logic                       valid
);

    logic [FLOAT_WIDTH-1:0]     wFixed;
    logic [FLOAT_WIDTH-1:0]     colorFloat   [4];
    logic [FLOAT_WIDTH-1:0]     colorFixed   [4];
    logic [SUB_PIXEL_WIDTH-1:0] colorClamped [4];
    fragMetaT                   metaIn;
    fragMetaT                   metaDelayed;

    ////////////////////////////////////////////////////////////
    // Depth and texture coordinates
    ////////////////////////////////////////////////////////////
    // z as 16.16
    floatToFixed #(.EXP_BIAS_OFFSET(-16)) convDepthZ
        (.clk(clk), .rst(rst), .in(fragIn.depthZ), .out(depthZ));

    // w as plain integer, only used to pick a fog entry
    floatToFixed #(.EXP_BIAS_OFFSET(0)) convDepthW
        (.clk(clk), .rst(rst), .in(fragIn.depthW), .out(wFixed));

    // Texture coordinates, 1.0 lands on bit 15
    floatToFixed #(.EXP_BIAS_OFFSET(-15)) convTexS
        (.clk(clk), .rst(rst), .in(fragIn.texS), .out(texS));
    floatToFixed #(.EXP_BIAS_OFFSET(-15)) convTexT
        (.clk(clk), .rst(rst), .in(fragIn.texT), .out(texT));

    assign fogIndex = (|wFixed[FLOAT_WIDTH-1:FOG_INDEX_WIDTH]) ? '1
                                                              : wFixed[FOG_INDEX_WIDTH-1:0];

    ////////////////////////////////////////////////////////////
    // Primary colour
    ////////////////////////////////////////////////////////////
    assign colorFloat[0] = fragIn.colorR;
    assign colorFloat[1] = fragIn.colorG;
    assign colorFloat[2] = fragIn.colorB;
    assign colorFloat[3] = fragIn.colorA;

    for (genvar i = 0; i < 4; i++)
    begin : gColor
        floatToFixed #(.EXP_BIAS_OFFSET(-16)) convColor
            (.clk(clk), .rst(rst), .in(colorFloat[i]), .out(colorFixed[i]));

        // Anything at or above 1.0 clamps to full intensity
        assign colorClamped[i] = (|colorFixed[i][31:16]) ? '1 : colorFixed[i][15:8];
    end

    assign color = '{r: colorClamped[0], g: colorClamped[1],
                     b: colorClamped[2], a: colorClamped[3]};

    ////////////////////////////////////////////////////////////
    // Metadata, depth filled in after conversion
    ////////////////////////////////////////////////////////////
    assign metaIn = '{index: fragIn.index, screenX: fragIn.screenX,
                      screenY: fragIn.screenY, depth: '0};

    valueDelay #(.payloadT(fragMetaT), .DELAY(CONVERT_LATENCY)) metaDelay (
        .clk      (clk),
        .rst      (rst),
        .inValid  (fragValid),
        .in       (metaIn),
        .outValid (valid),
        .out      (metaDelayed)
    );

    assign meta = '{index: metaDelayed.index, screenX: metaDelayed.screenX,
                    screenY: metaDelayed.screenY, depth: depthZ};

endmodule

`default_nettype wire

/* texEnvStage.sv */
// Texture fetch and environment combine
`timescale 1ns/10ps
`default_nettype none

module texEnvStage
    import pixelPkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire pipeConfT             conf,
    input  wire rgbaT                 color,
    input  wire [31:0]                texS,
    input  wire [31:0]                texT,
    input  wire                       inValid,
    output logic [TEX_ADDR_WIDTH-1:0] texelAddr,
    input  wire rgbaT                 texelData,
    output rgbaT                      outColor,
    output logic                      outValid
);

    rgbaT color1;
    rgbaT color2;
    rgbaT combined;
    logic valid1;
    logic valid2;

    function automatic logic [SUB_PIXEL_WIDTH-1:0] combineChannel(
        input texModeT                    mode,
        input logic [SUB_PIXEL_WIDTH-1:0] texel,
        input logic [SUB_PIXEL_WIDTH-1:0] prim
    );
        logic [2*SUB_PIXEL_WIDTH-1:0] product;
        logic [SUB_PIXEL_WIDTH:0]     sum;
        // Scaling by prim + 1 keeps 255 * 255 at 255
        product = texel * (prim + 9'd1);
        sum     = texel + prim;
        case (mode)
            REPLACE:  return texel;
            MODULATE: return product[2*SUB_PIXEL_WIDTH-1:SUB_PIXEL_WIDTH];
            ADD:      return sum[SUB_PIXEL_WIDTH] ? '1 : sum[SUB_PIXEL_WIDTH-1:0];
            default:  return prim;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Cycle 1: texel address, 256x256 texels repeating each 1.0
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        texelAddr <= {texT[14:7], texS[14:7]};
        color1    <= color;
        color2    <= color1;
        outColor  <= conf.texEnable ? combined : color2;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid1   <= 1'b0;
            valid2   <= 1'b0;
            outValid <= 1'b0;
        end
        else
        begin
            valid1   <= inValid;
            valid2   <= valid1;
            outValid <= valid2;
        end
    end

    ////////////////////////////////////////////////////////////
    // Cycle 3: texel has arrived from memory
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        combined.r = combineChannel(conf.texMode, texelData.r, color2.r);
        combined.g = combineChannel(conf.texMode, texelData.g, color2.g);
        combined.b = combineChannel(conf.texMode, texelData.b, color2.b);
        combined.a = combineChannel(conf.texMode, texelData.a, color2.a);
    end

endmodule

`default_nettype wire

/* fogStage.sv */
// Fog table and fog blend
`timescale 1ns/10ps
`default_nettype none

module fogStage
    import pixelPkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire pipeConfT               conf,
    input  wire [LUT_STREAM_WIDTH-1:0]  lutData,
    input  wire                         lutValid,
    input  wire                         lutLast,
    input  wire rgbaT                   color,
    input  wire [FOG_INDEX_WIDTH-1:0]   fogIndex,
    input  wire                         inValid,
    output rgbaT                        outColor,
    output logic                        outValid
);

    logic [SUB_PIXEL_WIDTH-1:0]   fogLut [FOG_LUT_DEPTH];
    logic [$clog2(LUT_BEATS)-1:0] wrPtr;
    logic [SUB_PIXEL_WIDTH-1:0]   factor1;
    rgbaT                         color1;
    rgbaT                         fogged;
    logic                         valid1;

    function automatic logic [SUB_PIXEL_WIDTH-1:0] fogChannel(
        input logic [SUB_PIXEL_WIDTH-1:0] c,
        input logic [SUB_PIXEL_WIDTH-1:0] fc,
        input logic [SUB_PIXEL_WIDTH-1:0] f
    );
        logic [2*SUB_PIXEL_WIDTH-1:0] mix;
        // Weights sum to 256, so the result never exceeds 255
        mix = c * (f + 9'd1) + fc * (9'd255 - f);
        return mix[2*SUB_PIXEL_WIDTH-1:SUB_PIXEL_WIDTH];
    endfunction

    ////////////////////////////////////////////////////////////
    // Table load, eight factors per beat
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (lutValid)
        begin
            for (int i = 0; i < LUT_BYTES_PER_BEAT; i++)
            begin
                fogLut[wrPtr * LUT_BYTES_PER_BEAT + i] <=
                    lutData[i * SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH];
            end
        end
    end

    // Last beat rewinds for the next load
    always_ff @(posedge clk)
    begin
        if (rst)
            wrPtr <= '0;
        else if (lutValid)
            wrPtr <= lutLast ? '0 : wrPtr + 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Cycle 1 reads the factor, cycle 2 blends
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        factor1  <= fogLut[fogIndex];
        color1   <= color;
        outColor <= conf.fogEnable ? fogged : color1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid1   <= 1'b0;
            outValid <= 1'b0;
        end
        else
        begin
            valid1   <= inValid;
            outValid <= valid1;
        end
    end

    always_comb
    begin
        fogged.r = fogChannel(color1.r, conf.fogColor.r, factor1);
        fogged.g = fogChannel(color1.g, conf.fogColor.g, factor1);
        fogged.b = fogChannel(color1.b, conf.fogColor.b, factor1);
        fogged.a = fogChannel(color1.a, conf.fogColor.a, factor1);
    end

endmodule

`default_nettype wire

/* pixelPipeline.sv */
// Fragment pipeline top level
`timescale 1ns/10ps
`default_nettype none

module pixelPipeline
    import pixelPkg::*;
(
    input  wire                         aclk,
    input  wire                         rst,
    input  wire pipeConfT               conf,
    input  wire fragmentInT             fragIn,
    input  wire                         fragValid,
    input  wire [LUT_STREAM_WIDTH-1:0]  lutData,
    input  wire                         lutValid,
    input  wire                         lutLast,
    output logic [TEX_ADDR_WIDTH-1:0]   texelAddr,
    input  wire rgbaT                   texelData,
    output rgbaT                        outColor,
    output fragMetaT                    outMeta,
    output logic                        outValid
);

    rgbaT                       convColor;
    logic [31:0]                convTexS;
    logic [31:0]                convTexT;
    logic [FOG_INDEX_WIDTH-1:0] convFogIndex;
    fragMetaT                   convMeta;
    logic                       convValid;
    rgbaT                       texColor;
    logic                       texValid;
    logic [FOG_INDEX_WIDTH-1:0] texFogIndex;

    ////////////////////////////////////////////////////////////
    // Float to fixed, 4 cycles
    ////////////////////////////////////////////////////////////
    // Depth z already rides inside convMeta
    attributeConvert convert (
        .clk      (aclk),
        .rst      (rst),
        .fragIn   (fragIn),
        .fragValid(fragValid),
        .color    (convColor),
        .texS     (convTexS),
        .texT     (convTexT),
        .depthZ   (),
        .fogIndex (convFogIndex),
        .meta     (convMeta),
        .valid    (convValid)
    );

    ////////////////////////////////////////////////////////////
    // Texture, 3 cycles
    ////////////////////////////////////////////////////////////
    texEnvStage texEnv (
        .clk      (aclk),
        .rst      (rst),
        .conf     (conf),
        .color    (convColor),
        .texS     (convTexS),
        .texT     (convTexT),
        .inValid  (convValid),
        .texelAddr(texelAddr),
        .texelData(texelData),
        .outColor (texColor),
        .outValid (texValid)
    );

    // Fog index waits out the texture stage
    valueDelay #(.payloadT(logic [FOG_INDEX_WIDTH-1:0]), .DELAY(TEX_LATENCY)) fogIndexDelay (
        .clk(aclk), .rst(rst), .inValid(convValid), .in(convFogIndex),
        .outValid(), .out(texFogIndex)
    );

    ////////////////////////////////////////////////////////////
    // Fog, 2 cycles
    ////////////////////////////////////////////////////////////
    fogStage fog (
        .clk(aclk), .rst(rst), .conf(conf),
        .lutData(lutData), .lutValid(lutValid), .lutLast(lutLast),
        .color(texColor), .fogIndex(texFogIndex), .inValid(texValid),
        .outColor(outColor), .outValid(outValid)
    );

    // Metadata runs beside texture and fog
    valueDelay #(.payloadT(fragMetaT), .DELAY(TEX_LATENCY + FOG_LATENCY)) metaDelay (
        .clk(aclk), .rst(rst), .inValid(convValid), .in(convMeta),
        .outValid(), .out(outMeta)
    );

endmodule

`default_nettype wire

/* pixelPipeline_props.sv */
// Pipeline timing properties
`timescale 1ns/10ps
`default_nettype none

module pixelPipelineProps
    import pixelPkg::*;
(
    input wire                      clk,
    input wire                      rst,
    input wire pipeConfT            conf,
    input wire                      fragValid,
    input wire                      outValid,
    input wire                      texInValid,
    input wire [31:0]               texS,
    input wire [31:0]               texT,
    input wire [TEX_ADDR_WIDTH-1:0] texelAddr
);

    ////////////////////////////////////////////////////////////
    // Valid timing
    ////////////////////////////////////////////////////////////
    resetClearsValid: assert property (@(posedge clk) rst |=> !outValid)
        else $error("outValid still high after a reset cycle");

    // One valid register per cycle of latency
    fixedLatency: assert property (@(posedge clk) disable iff (rst)
        outValid == $past(fragValid, PIPE_LATENCY))
        else $error("outValid does not follow fragValid by %0d cycles", PIPE_LATENCY);

    ////////////////////////////////////////////////////////////
    // Texel addressing
    ////////////////////////////////////////////////////////////
    // Bits 14:7 of each coordinate, t above s
    texelAddress: assert property (@(posedge clk) disable iff (rst)
        (texInValid && conf.texEnable)
        |=> texelAddr == {$past(texT[14:7]), $past(texS[14:7])})
        else $error("texelAddr does not match the texture coordinates");

endmodule

bind pixelPipeline pixelPipelineProps timingProps (
    .clk       (aclk),
    .rst       (rst),
    .conf      (conf),
    .fragValid (fragValid),
    .outValid  (outValid),
    .texInValid(convValid),
    .texS      (convTexS),
    .texT      (convTexT),
    .texelAddr (texelAddr)
);

`default_nettype wire

/* pixelPipelineTb.sv */
// Fragment pipeline testbench
`timescale 1ns/10ps
`default_nettype none

module pixelPipelineTb
    import pixelPkg::*;
();

    typedef struct packed {
        rgbaT     color;
        fragMetaT meta;
    } expectT;

    logic                        clk = 1'b0;
    logic                        rst;
    pipeConfT                    conf;
    fragmentInT                  fragIn;
    logic                        fragValid;
    logic [LUT_STREAM_WIDTH-1:0] lutData;
    logic                        lutValid;
    logic                        lutLast;
    logic [TEX_ADDR_WIDTH-1:0]   texelAddr;
    rgbaT                        texelData = '0;
    rgbaT                        outColor;
    fragMetaT                    outMeta;
    logic                        outValid;

    logic [7:0] fogModel [FOG_LUT_DEPTH];
    expectT     expQ [$];
    int         dueQ [$];
    int         cycle = 0;
    int         checks = 0;
    int         errors = 0;
    int         timeouts = 0;
    string      testName;

    always #50 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    pixelPipeline dut_i (
        .aclk     (clk),
        .rst      (rst),
        .conf     (conf),
        .fragIn   (fragIn),
        .fragValid(fragValid),
        .lutData  (lutData),
        .lutValid (lutValid),
        .lutLast  (lutLast),
        .texelAddr(texelAddr),
        .texelData(texelData),
        .outColor (outColor),
        .outMeta  (outMeta),
        .outValid (outValid)
    );

    ////////////////////////////////////////////////////////////
    // Texture memory, one cycle read latency
    ////////////////////////////////////////////////////////////
    function automatic rgbaT texelOf(input logic [TEX_ADDR_WIDTH-1:0] addr);
        rgbaT t;
        t.r = addr[7:0];
        t.g = addr[15:8];
        t.b = addr[7:0] + addr[15:8];
        t.a = 8'hFF;
        return t;
    endfunction

    always @(posedge clk)
        texelData <= texelOf(texelAddr);

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    // Float of n * 2^-k, n below 2^24
    function automatic logic [31:0] makeFloat(input logic neg, input logic [31:0] n, input int k);
        int          msb;
        logic [31:0] mant;
        logic [7:0]  biased;
        msb = 0;
        if (n == 0)
            return {neg, 31'b0};
        for (int i = 0; i < 24; i++)
            if (n[i])
                msb = i;
        mant   = n << (23 - msb);
        biased = 8'(127 + msb - k);
        return {neg, biased, mant[22:0]};
    endfunction

    // Truncated n * 2^(s-k), saturating at 32 bits
    function automatic logic [31:0] toFixed(input logic [31:0] n, input int k, input int s,
                                            input logic neg);
        longint unsigned v;
        v = n;
        if (neg || n == 0)
            return '0;
        if (s >= k)
            v = v << (s - k);
        else
            v = v >> (k - s);
        return (v > 64'hFFFF_FFFF) ? 32'hFFFF_FFFF : v[31:0];
    endfunction

    function automatic logic [7:0] expectCombine(input texModeT mode, input logic [7:0] tx,
                                                 input logic [7:0] c);
        int product;
        int sum;
        product = (int'(tx) * (int'(c) + 1)) >> 8;
        sum     = int'(tx) + int'(c);
        case (mode)
            MODULATE: return 8'(product);
            ADD:      return (sum > 255) ? 8'hFF : 8'(sum);
            default:  return tx;
        endcase
    endfunction

    function automatic logic [7:0] blendFog(input logic [7:0] c, input logic [7:0] fc,
                                            input logic [7:0] f);
        return 8'((int'(c) * (int'(f) + 1) + int'(fc) * (255 - int'(f))) >> 8);
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////
    task automatic sendFragment(input int unsigned colorMax, input int unsigned wMax);
        fragmentInT  frag;
        expectT      want;
        logic [31:0] colN [4];
        logic        colNeg [4];
        logic [31:0] colF [4];
        logic [31:0] zN;
        logic [31:0] sN;
        logic [31:0] tN;
        logic [31:0] wN;
        logic [31:0] fixed;
        logic [31:0] sFix;
        logic [31:0] tFix;
        logic [31:0] wFix;
        logic [31:0] color;
        logic [31:0] texel;
        logic [7:0]  factor;
        // Configuration written at an earlier edge has settled here
        @(posedge clk);
        // Channel i = 0 is red, the top byte
        for (int i = 0; i < 4; i++)
        begin
            colN[i]   = $urandom_range(colorMax, 0);
            colNeg[i] = ($urandom_range(7, 0) == 0);
            colF[i]   = makeFloat(colNeg[i], colN[i], 11);
            fixed     = toFixed(colN[i], 11, 16, colNeg[i]);
            color[8*(3-i) +: 8] = (fixed[31:16] != 0) ? 8'hFF : fixed[15:8];
        end
        zN = $urandom_range(32'hF_FFFF, 0);
        sN = $urandom_range(1023, 0);
        tN = $urandom_range(1023, 0);
        wN = $urandom_range(wMax, 0);
        frag.index   = 14'($urandom);
        frag.screenX = 11'($urandom);
        frag.screenY = 11'($urandom);
        frag.depthZ  = makeFloat(1'b0, zN, 10);
        frag.depthW  = makeFloat(1'b0, wN, 0);
        frag.texS    = makeFloat(1'b0, sN, 8);
        frag.texT    = makeFloat(1'b0, tN, 8);
        frag.colorR  = colF[0];
        frag.colorG  = colF[1];
        frag.colorB  = colF[2];
        frag.colorA  = colF[3];
        want.meta = '{index: frag.index, screenX: frag.screenX, screenY: frag.screenY,
                      depth: toFixed(zN, 10, 16, 1'b0)};
        if (conf.texEnable)
        begin
            sFix  = toFixed(sN, 8, 15, 1'b0);
            tFix  = toFixed(tN, 8, 15, 1'b0);
            texel = texelOf({tFix[14:7], sFix[14:7]});
            for (int i = 0; i < 4; i++)
                color[8*i +: 8] = expectCombine(conf.texMode, texel[8*i +: 8], color[8*i +: 8]);
        end
        if (conf.fogEnable)
        begin
            wFix   = toFixed(wN, 0, 0, 1'b0);
            factor = fogModel[(wFix > 63) ? 6'd63 : wFix[5:0]];
            for (int i = 0; i < 4; i++)
                color[8*i +: 8] = blendFog(color[8*i +: 8], conf.fogColor[8*i +: 8], factor);
        end
        want.color = color;
        fragIn    <= frag;
        fragValid <= 1'b1;
        expQ.push_back(want);
    endtask

    task automatic loadFogTable();
        logic [LUT_STREAM_WIDTH-1:0] beat;
        for (int b = 0; b < LUT_BEATS; b++)
        begin
            for (int i = 0; i < LUT_BYTES_PER_BEAT; i++)
            begin
                fogModel[b * LUT_BYTES_PER_BEAT + i] = 8'($urandom);
                beat[8*i +: 8] = fogModel[b * LUT_BYTES_PER_BEAT + i];
            end
            @(posedge clk);
            lutData  <= beat;
            lutValid <= 1'b1;
            lutLast  <= (b == LUT_BEATS - 1);
        end
        @(posedge clk);
        lutValid <= 1'b0;
        lutLast  <= 1'b0;
    endtask

    // Only called with the pipeline empty
    task automatic applyConfig(input logic texOn, input texModeT mode, input logic fogOn);
        pipeConfT c;
        c.texEnable = texOn;
        c.texMode   = mode;
        c.fogEnable = fogOn;
        c.fogColor  = rgbaT'($urandom);
        @(posedge clk);
        conf <= c;
    endtask

    task automatic reportAndFinish();
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    endtask

    task automatic drainPipeline();
        int waited;
        waited = 0;
        @(posedge clk);
        fragValid <= 1'b0;
        // Generous bound, the last fragment needs PIPE_LATENCY edges
        while (expQ.size() != 0 && waited < 4 * PIPE_LATENCY)
        begin
            @(posedge clk);
            waited++;
        end
        if (expQ.size() != 0)
        begin
            $display("Timeout in %s: %0d fragments never came out", testName, expQ.size());
            timeouts++;
            reportAndFinish();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Output checks at the falling edge
    ////////////////////////////////////////////////////////////
    always @(negedge clk)
    begin : checkOutputs
        expectT want;
        int     due;
        if (rst)
        begin
            assert (outValid == 1'b0)
            else
            begin
                $display("outValid is high while reset is asserted");
                errors++;
            end
        end
        else if (outValid)
        begin
            assert (expQ.size() != 0)
            else
            begin
                $display("Output in %s at cycle %0d with no fragment in flight", testName, cycle);
                errors++;
            end
            if (expQ.size() != 0)
            begin
                want = expQ.pop_front();
                due  = dueQ.pop_front();
                checks++;
                assert (outColor == want.color)
                else
                begin
                    $display("[FAIL] %s color: expected %h, actual %h",
                             testName, want.color, outColor);
                    errors++;
                end
                assert (outMeta == want.meta)
                else
                begin
                    $display("[FAIL] %s meta: expected %h, actual %h",
                             testName, want.meta, outMeta);
                    errors++;
                end
                assert (cycle == due)
                else
                begin
                    $display("[FAIL] %s output cycle: expected %0d, actual %0d",
                             testName, due, cycle);
                    errors++;
                end
            end
        end
        // Accepted at the next edge, seen here after PIPE_LATENCY more edges
        if (fragValid)
            dueQ.push_back(cycle + PIPE_LATENCY);
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        void'($urandom(32'h5252_eede));
        rst       = 1'b1;
        conf      = '0;
        fragIn    = '0;
        fragValid = 1'b0;
        lutData   = '0;
        lutValid  = 1'b0;
        lutLast   = 1'b0;
        testName  = "reset";
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Quiet outputs, then the first fragment alone
        repeat (6) @(posedge clk);
        testName = "first fragment";
        sendFragment(2047, 63);
        drainPipeline();

        testName = "conversion";
        repeat (24) sendFragment(4095, 100);
        drainPipeline();

        for (int m = 0; m < 3; m++)
        begin
            applyConfig(1'b1, texModeT'(m), 1'b0);
            testName = $sformatf("texture mode %0d", m);
            repeat (16) sendFragment(4095, 100);
            drainPipeline();
        end

        testName = "fog";
        loadFogTable();
        applyConfig(1'b0, REPLACE, 1'b1);
        repeat (20) sendFragment(4095, 100);
        drainPipeline();

        // Back to back, a fresh random mode per burst
        testName = "burst";
        for (int r = 0; r < 4; r++)
        begin
            applyConfig(1'($urandom), texModeT'($urandom_range(2, 0)), 1'($urandom));
            repeat (32) sendFragment(4095, 100);
            drainPipeline();
        end

        reportAndFinish();
    end

endmodule

`default_nettype wire

/* pixelPipeline.f */
pixelPkg.sv
floatToFixed.sv
valueDelay.sv
attributeConvert.sv
texEnvStage.sv
fogStage.sv
pixelPipeline.sv
pixelPipeline_props.sv
pixelPipelineTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = pixelPipelineTb
FILELIST = pixelPipeline.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJDIR)
